// ==== hdl/elementStore.sv ====
// Element store
// Element memory with in-place add, sub, and, or and xor

`default_nettype none
`include "heap_defs.svh"

module elementStore
  import heapPkg::*;
(
  input  logic       clock,
  input  logic       reqValid,
  input  heapCommand req,
  input  heapError   accessError,
  input  elemSize    size,                         // Size of the addressed array
  output elemData    elemValue                     // Value the command returns
);

  elemData  mem [`HEAP_ARRAYS][`HEAP_LENGTH];
  elemIndex slot;                                  // Element touched by this command
  elemData  oldValue;
  logic     storeOp;                               // Op writes the element back

  // Push appends, pop takes the top, others use the index
  always_comb begin
    case (req.op)
      opPush:  slot = elemIndex'(size);
      opPop:   slot = elemIndex'(size - 1'b1);
      default: slot = req.index;
    endcase
  end

  assign oldValue = mem[req.array][slot];
  assign storeOp  = req.op inside {opWrite, opPush, opAdd, opSub, opAnd, opOr, opXor};

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  always_comb begin
    case (req.op)
      opWrite, opPush: elemValue = req.data;
      opAdd:           elemValue = oldValue + req.data;  // Wraps at 16 bits
      opSub:           elemValue = oldValue - req.data;
      opAnd:           elemValue = oldValue & req.data;
      opOr:            elemValue = oldValue | req.data;
      opXor:           elemValue = oldValue ^ req.data;
      default:         elemValue = oldValue;      // Read and pop
    endcase
  end

  always_ff @(posedge clock) begin
    if (reqValid && accessError == errNone && storeOp) begin
      mem[req.array][slot] <= elemValue;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/heapAccessCheck.sv ====
// Heap access check
// Judges each command against allocation and size state, first failing check wins

`default_nettype none
`include "heap_defs.svh"

module heapAccessCheck
  import heapPkg::*;
(
  input  heapCommand req,
  input  logic       allocated,                    // Allocated bit of the addressed array
  input  elemSize    highWater,                    // Arrays ever handed out
  input  elemSize    size,                         // Size of the addressed array
  output heapError   accessError
);

  elemSize arrayExt;                               // Array number widened for compare
  elemSize indexExt;                               // Index widened for compare
  logic    needsArray;                             // Op addresses an existing array

  assign arrayExt   = elemSize'(req.array);
  assign indexExt   = elemSize'(req.index);
  assign needsArray = !(req.op inside {opClear, opAlloc});

  always_comb begin
    accessError = errNone;
    if (needsArray) begin
      if (arrayExt >= highWater) begin
        accessError = errNeverAllocated;           // Never handed out
      end else if (!allocated) begin
        accessError = errFreed;
      end else begin
        case (req.op)
          opRead, opAdd, opSub, opAnd, opOr, opXor: begin
            if (indexExt >= size) accessError = errBounds;
          end
          opPush: begin
            if (size >= elemSize'(`HEAP_LENGTH)) accessError = errFull;
          end
          opPop: begin
            if (size == '0) accessError = errEmpty;
          end
          default: ;                               // Write, size and free only need the array
        endcase
      end
    end
  end

  // An allocated array always lies below high water
  always_comb begin
    aAllocBelowHighWater: assert final (allocated !== 1'b1 || arrayExt < highWater);
  end

endmodule

`default_nettype wire

// ==== hdl/heapAllocator.sv ====
// Heap allocator
// Allocated bits, stack of freed arrays and the high-water counter

`default_nettype none
`include "heap_defs.svh"

module heapAllocator
  import heapPkg::*;
(
  input  logic       clock,
  input  logic       resetN,
  input  logic       reqValid,
  input  heapCommand req,
  input  heapError   accessError,
  output logic       allocated,                    // Bit of the addressed array
  output elemSize    highWater,
  output arrayId     allocArray,                   // Array an alloc would return now
  output logic       noMemory                      // Nothing left to allocate
);

  logic [`HEAP_ARRAYS-1:0] allocBits;
  arrayId                  freedStack [`HEAP_ARRAYS];
  elemSize                 freedTop;               // Entries on the freed stack
  elemSize                 highWaterQ;
  logic                    freedAvail;
  logic                    doCmd;                  // Command accepted this cycle

  assign doCmd      = reqValid && accessError == errNone;
  assign freedAvail = freedTop != '0;
  assign allocated  = allocBits[req.array];
  assign highWater  = highWaterQ;
  assign noMemory   = !freedAvail && highWaterQ == elemSize'(`HEAP_ARRAYS);

  // Most recently freed first, else next fresh array
  assign allocArray = freedAvail ? freedStack[arrayId'(freedTop - 1'b1)]
                                 : arrayId'(highWaterQ);

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocBits  <= '0;
      freedTop   <= '0;
      highWaterQ <= '0;
    end else if (doCmd) begin
      case (req.op)
        opClear: begin
          allocBits  <= '0;
          freedTop   <= '0;                        // Drop the freed stack
          highWaterQ <= '0;
        end
        opAlloc: begin
          if (freedAvail) begin
            freedTop              <= freedTop - 1'b1;  // Reuse
            allocBits[allocArray] <= 1'b1;
          end else if (!noMemory) begin
            highWaterQ            <= highWaterQ + 1'b1;
            allocBits[allocArray] <= 1'b1;
          end
        end
        opFree: begin
          allocBits[req.array] <= 1'b0;
          freedTop             <= freedTop + 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Freed stack contents
  always_ff @(posedge clock) begin
    if (doCmd && req.op == opFree) begin
      freedStack[arrayId'(freedTop)] <= req.array;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  aFreedDepth: assert property (@(posedge clock) disable iff (!resetN)
    freedTop <= elemSize'(`HEAP_ARRAYS));

  aAllocUnique: assert property (@(posedge clock) disable iff (!resetN)
    doCmd && req.op == opAlloc && !noMemory |-> !allocBits[allocArray]);

endmodule

`default_nettype wire

// ==== hdl/heapPkg.sv ====
// Heap types
// Opcodes, error codes and the command and response structs

`default_nettype none

package heapPkg;
  `include "heap_defs.svh"

  // ----------------------------------------
  // Opcodes and errors
  // ----------------------------------------
  typedef enum logic [3:0] {
    opClear = 4'd0,                                // Forget all arrays
    opAlloc = 4'd1,                                // New array, returns its number
    opFree  = 4'd2,                                // Release an array for reuse
    opWrite = 4'd3,                                // Store one element
    opRead  = 4'd4,                                // Fetch one element
    opSize  = 4'd5,                                // Current array size
    opPush  = 4'd6,                                // Append at the top
    opPop   = 4'd7,                                // Remove from the top
    opAdd   = 4'd8,                                // In place, new value returned
    opSub   = 4'd9,
    opAnd   = 4'd10,
    opOr    = 4'd11,
    opXor   = 4'd12
  } heapOp;

  typedef enum logic [2:0] {
    errNone           = 3'd0,
    errNeverAllocated = 3'd1,                      // At or above high water
    errFreed          = 3'd2,                      // Below high water but released
    errBounds         = 3'd3,                      // Index not below size
    errFull           = 3'd4,                      // Push to a full array
    errEmpty          = 3'd5,                      // Pop from an empty array
    errNoMemory       = 3'd6                       // No array left to allocate
  } heapError;

  // ----------------------------------------
  // Field types and structs
  // ----------------------------------------
  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayId;
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIndex;
  typedef logic [`HEAP_INDEX_BITS:0]   elemSize;   // One extra bit to hold a full count
  typedef logic [`HEAP_DATA_BITS-1:0]  elemData;

  typedef struct packed {
    heapOp    op;
    arrayId   array;
    elemIndex index;
    elemData  data;                                // Operand for write, push and arithmetic
  } heapCommand;

  typedef struct packed {
    elemData  data;
    heapError error;
  } heapResult;
endpackage

`default_nettype wire

// ==== hdl/heapResponse.sv ====
// Heap response
// Picks the returned data by opcode and registers it with the response strobe

`default_nettype none

module heapResponse
  import heapPkg::*;
(
  input  logic       clock,
  input  logic       resetN,
  input  logic       reqValid,
  input  heapCommand req,
  input  heapError   accessError,
  input  logic       noMemory,
  input  arrayId     allocArray,
  input  elemSize    size,
  input  elemData    elemValue,
  output logic       respValid,
  output heapResult  resp
);

  heapError respError;
  elemData  respData;

  always_comb begin
    respError = accessError;
    if (req.op == opAlloc && noMemory) respError = errNoMemory;  // Only alloc can run out
    case (req.op)
      opAlloc:         respData = elemData'(allocArray);
      opSize:          respData = elemData'(size);
      opFree, opClear: respData = '0;
      default:         respData = elemValue;
    endcase
    if (respError != errNone) respData = '0;  // Failed commands return zero
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) respValid <= 1'b0;
    else         respValid <= reqValid;        // One cycle after the request
  end

  always_ff @(posedge clock) begin
    if (reqValid) resp <= '{data: respData, error: respError};
  end

  // Alloc errors come only from running out
  aAllocNoAccessError: assert property (@(posedge clock) disable iff (!resetN)
    reqValid && req.op == opAlloc |-> accessError == errNone);

endmodule

`default_nettype wire

// ==== hdl/heapTop.sv ====
// Heap top level
// Fans each command out to the allocator, size table and element store

`default_nettype none

module heapTop
  import heapPkg::*;
(
  input  logic       clock,
  input  logic       resetN,
  input  logic       reqValid,
  input  heapCommand req,
  output logic       respValid,
  output heapResult  resp
);

  logic     allocated;
  elemSize  highWater;
  arrayId   allocArray;
  logic     noMemory;
  elemSize  size;                                  // Size of the addressed array
  heapError accessError;
  elemData  elemValue;

  // ----------------------------------------
  // Legality
  // ----------------------------------------
  heapAccessCheck uCheck (
    .req         (req),
    .allocated   (allocated),
    .highWater   (highWater),
    .size        (size),
    .accessError (accessError)
  );

  // ----------------------------------------
  // State owners
  // ----------------------------------------
  heapAllocator uAlloc (
    .clock       (clock),
    .resetN      (resetN),
    .reqValid    (reqValid),
    .req         (req),
    .accessError (accessError),
    .allocated   (allocated),
    .highWater   (highWater),
    .allocArray  (allocArray),
    .noMemory    (noMemory)
  );

  sizeTable uSizes (
    .clock       (clock),
    .resetN      (resetN),
    .reqValid    (reqValid),
    .req         (req),
    .accessError (accessError),
    .noMemory    (noMemory),
    .allocArray  (allocArray),
    .size        (size)
  );

  elementStore uStore (
    .clock       (clock),
    .reqValid    (reqValid),
    .req         (req),
    .accessError (accessError),
    .size        (size),
    .elemValue   (elemValue)
  );

  heapResponse uResp (
    .clock       (clock),
    .resetN      (resetN),
    .reqValid    (reqValid),
    .req         (req),
    .accessError (accessError),
    .noMemory    (noMemory),
    .allocArray  (allocArray),
    .size        (size),
    .elemValue   (elemValue),
    .respValid   (respValid),
    .resp        (resp)
  );

endmodule

`default_nettype wire

// ==== hdl/heap_defs.svh ====
// Heap geometry
// Array count, array length and element width shared by the package and the RTL

`ifndef HEAP_DEFS_SVH
`define HEAP_DEFS_SVH

// ----------------------------------------
// Base widths
// ----------------------------------------
`define HEAP_ARRAY_BITS 3                          // Bits in an array number
`define HEAP_INDEX_BITS 3                          // Bits in an element index
`define HEAP_DATA_BITS  16                         // Element width

// ----------------------------------------
// Derived sizes
// ----------------------------------------
`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)        // Number of arrays
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)        // Elements per array

`endif

// ==== hdl/sizeTable.sv ====
// Array size table
// One size per array, zeroed on alloc, grown by write and push, shrunk by pop

`default_nettype none
`include "heap_defs.svh"

module sizeTable
  import heapPkg::*;
(
  input  logic       clock,
  input  logic       resetN,
  input  logic       reqValid,
  input  heapCommand req,
  input  heapError   accessError,
  input  logic       noMemory,
  input  arrayId     allocArray,                   // Array an alloc hands out
  output elemSize    size                          // Size of the addressed array
);

  elemSize sizes [`HEAP_ARRAYS];
  elemSize indexNext;                              // Size implied by a write
  logic    doCmd;

  assign doCmd     = reqValid && accessError == errNone;
  assign size      = sizes[req.array];
  assign indexNext = elemSize'(req.index) + 1'b1;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      sizes <= '{default: '0};
    end else if (doCmd) begin
      case (req.op)
        opAlloc: begin
          if (!noMemory) sizes[allocArray] <= '0;  // Fresh or reused, starts empty
        end
        opWrite: begin
          if (indexNext > size) sizes[req.array] <= indexNext;
        end
        opPush: begin
          sizes[req.array] <= size + 1'b1;
        end
        opPop: begin
          sizes[req.array] <= size - 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Full and empty checks live in the access checker
  for (genvar a = 0; a < `HEAP_ARRAYS; a++) begin : gSizeLimit
    aSizeLimit: assert property (@(posedge clock) disable iff (!resetN)
      sizes[a] <= elemSize'(`HEAP_LENGTH));
  end

endmodule

`default_nettype wire

// ==== test/heapTb.sv ====
// Heap testbench
// Plays the command table from the tests file through the heap and checks
// every response strobe, its data and its error code

`default_nettype none

module heapTb
  import heapPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MaxLines = 64;                    // Table capacity in commands
  localparam int Columns  = 6;                     // Words per table line

  logic       clock;
  logic       resetN;
  logic       reqValid;
  heapCommand req;
  logic       respValid;
  heapResult  resp;

  logic [15:0] testTable [Columns*MaxLines];
  int          lineCount;
  int          cycleLimit;
  int          cycleCount;
  int          errorCount;
  int          checkCount;

  elemData  expData;                               // Expected result of the line on req
  heapError expErr;
  int       lineNum;
  logic     wasValid;                              // Request seen at the last falling edge
  elemData  heldData;
  heapError heldErr;
  int       heldLine;

  heapTop UUT (
    .clock     (clock),
    .resetN    (resetN),
    .reqValid  (reqValid),
    .req       (req),
    .respValid (respValid),
    .resp      (resp)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;                       // 100 ns period

  // ----------------------------------------
  // Table access
  // ----------------------------------------
  function automatic int countLines();
    int n;
    n = 0;
    while (n < MaxLines && testTable[n*Columns] !== 16'h000f) n++;  // Op f ends the table
    return n;
  endfunction

  task automatic driveLine(input int n);
    int base;
    base = n * Columns;
    @(posedge clock);
    reqValid  <= 1'b1;
    req.op    <= heapOp'(testTable[base][3:0]);
    req.array <= arrayId'(testTable[base+1]);
    req.index <= elemIndex'(testTable[base+2]);
    req.data  <= testTable[base+3];
    expData   <= testTable[base+4];
    expErr    <= heapError'(testTable[base+5][2:0]);
    lineNum   <= n + 1;                            // Line numbers count from 1
  endtask

  task automatic idleCycle();
    @(posedge clock);
    reqValid <= 1'b0;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    $timeformat(-9, 0, "", 0);                     // Times in whole ns
    resetN     = 1'b0;
    reqValid   = 1'b0;
    req        = '0;
    expData    = '0;
    expErr     = errNone;
    lineNum    = 0;
    wasValid   = 1'b0;
    heldData   = '0;
    heldErr    = errNone;
    heldLine   = 0;
    errorCount = 0;
    checkCount = 0;
    cycleCount = 0;
    $readmemh("test/heapTests.txt", testTable);
    lineCount  = countLines();
    cycleLimit = 2 * lineCount + 20;
    if (lineCount == 0) begin
      $display("Test table is empty or could not be read");
      errorCount++;
    end
    repeat (8) @(posedge clock);                   // Reset for 8 cycles
    resetN <= 1'b1;
    for (int n = 0; n < lineCount; n++) begin
      driveLine(n);
      if (n % 3 == 2) idleCycle();                 // Gap after every third command
    end
    idleCycle();
    repeat (2) @(posedge clock);                   // Let the last response drain
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // ----------------------------------------
  // Response check
  // ----------------------------------------
  always @(negedge clock) begin
    if (resetN) begin
      if (wasValid) begin
        checkCount++;
        if (!respValid) begin
          $display("No respValid at %0t ns for test line %0d", $time, heldLine);
          errorCount++;
        end else begin
          if (resp.data !== heldData) begin
            $display("** Error at %0t ns: resp.data = %h, expected %h (line %0d)",
                     $time, resp.data, heldData, heldLine);
            errorCount++;
          end
          if (resp.error !== heldErr) begin
            $display("** Error at %0t ns: resp.error = %0d, expected %0d (line %0d)",
                     $time, resp.error, heldErr, heldLine);
            errorCount++;
          end
        end
      end else if (respValid) begin
        $display("respValid high at %0t ns with no request in the cycle before", $time);
        errorCount++;
      end
      wasValid = reqValid;                         // DUT samples this at the next edge
      heldData = expData;
      heldErr  = expErr;
      heldLine = lineNum;
    end
  end

  // Run limit from the table length
  always @(posedge clock) begin
    if (resetN) begin
      cycleCount++;
      if (cycleCount >= cycleLimit) begin
        $display("Timeout after %0d cycles, the table did not finish", cycleCount);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
        $display("** FAIL **");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/heapTests.txt ====
// Columns: op array index data expectedData expectedError, all hex
// Ops and errors use the heapOp and heapError codes; op f ends the table
0 0 0 0000 0000 0   // Clear
1 0 0 0000 0000 0   // Alloc gives array 0
3 0 0 5555 5555 0
3 3 0 dead 0000 1   // Above high water
1 0 0 0000 0001 0
1 0 0 0000 0002 0
1 0 0 0000 0003 0
1 0 0 0000 0004 0
1 0 0 0000 0005 0
1 0 0 0000 0006 0
1 0 0 0000 0007 0
1 0 0 0000 0000 6   // Ninth alloc, none left
4 0 0 0000 5555 0   // Failed write left it alone
2 1 0 0000 0000 0
1 0 0 0000 0001 0   // Reuses array 1
3 2 5 1234 1234 0
5 2 0 0000 0006 0
4 2 5 0000 1234 0
4 2 6 0000 0000 3   // Past the size
6 1 0 1001 1001 0
6 1 0 1002 1002 0
6 1 0 1003 1003 0
6 1 0 1004 1004 0
6 1 0 1005 1005 0
6 1 0 1006 1006 0
6 1 0 1007 1007 0
6 1 0 1008 1008 0
6 1 0 1009 0000 4   // Full
7 1 0 0000 1008 0
7 1 0 0000 1007 0
5 1 0 0000 0006 0
7 3 0 0000 0000 5   // Empty
8 2 5 ffff 1233 0   // Add wraps
4 2 5 0000 1233 0
9 2 5 1300 ff33 0
a 2 5 0ff0 0f30 0
b 2 5 a005 af35 0
c 2 5 ffff 50ca 0
4 2 5 0000 50ca 0
2 4 0 0000 0000 0
3 4 0 beef 0000 2   // Write after free
2 4 0 0000 0000 2   // Second free
4 2 5 0000 50ca 0
4 1 0 0000 1001 0
f 0 0 0000 0000 0

// ==== vlog.f ====
+incdir+hdl
hdl/heapPkg.sv
hdl/heapAccessCheck.sv
hdl/heapAllocator.sv
hdl/sizeTable.sv
hdl/elementStore.sv
hdl/heapResponse.sv
hdl/heapTop.sv
test/heapTb.sv
